//--- logic/compute_engine_pkg.sv
package compute_engine_pkg;

    // flit geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;
    localparam int DEST_W = 3;

    // head descriptor layout
    localparam int DELAY_OF = 0;
    localparam int DELAY_W = 16;
    localparam int CHAIN_OF = 16;
    localparam int CHAIN_ITEMS = 4;
    localparam int CHAIN_ITEM_W = DEST_W;
    // picks between the two detour ports
    localparam int DETOUR_BIT = 28;

    // egress port numbers
    localparam logic [DEST_W-1:0] DETOUR_PORT_LO = 3'd0;
    localparam logic [DEST_W-1:0] DETOUR_PORT_HI = 3'd3;
    // dma engine, used once the hop chain runs out
    localparam logic [DEST_W-1:0] DMA_PORT = 3'd1;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } flit_t;

    typedef struct packed {
        flit_t             flit;
        logic [DEST_W-1:0] dest;
    } routed_flit_t;

    // sub in the upper bit, add in the lower bit
    typedef struct packed {
        logic sub;
        logic add;
    } credit_t;

endpackage

//--- logic/flit_if.sv
`timescale 1ns/1ps

interface flit_if;

    logic                                  valid;
    logic                                  ready;
    logic [compute_engine_pkg::DATA_W-1:0] data;
    logic [compute_engine_pkg::KEEP_W-1:0] keep;
    logic                                  last;
    logic [compute_engine_pkg::DEST_W-1:0] dest;

    modport source (
        output valid,
        input  ready,
        output data,
        output keep,
        output last,
        output dest
    );

    modport sink (
        input  valid,
        output ready,
        input  data,
        input  keep,
        input  last,
        input  dest
    );

endinterface

//--- logic/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo #(
    parameter int  DEPTH = 16,
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    output logic   in_ready,
    input  entry_t in_entry,
    output logic   out_valid,
    input  logic   out_ready,
    output entry_t out_entry
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // wraps at DEPTH so any depth works, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_entry = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    occupancy_bounded: assert property (
        @(posedge clk) disable iff (rst) count <= CNT_W'(DEPTH)
    );

endmodule

//--- logic/packet_admission.sv
`timescale 1ns/1ps

module packet_admission #(
    parameter int MAX_PACKETS = 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  compute_engine_pkg::flit_t in_flit,
    output logic                      buf_valid,
    input  logic                      buf_ready,
    output compute_engine_pkg::flit_t buf_flit,
    flit_if.source                    detour,
    input  logic                      release_pulse,
    output logic                      sub_credit
);

    localparam int CNT_W = $clog2(MAX_PACKETS + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_INSERT,
        ST_DETOUR
    } state_t;

    state_t                                state;
    logic [CNT_W-1:0]                      pkt_count;
    logic [compute_engine_pkg::DEST_W-1:0] detour_dest;
    logic                                  in_fire;

    assign in_fire = in_valid && in_ready;

    // path is chosen once per packet, on its head flit
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (in_valid) begin
                        if (pkt_count < CNT_W'(MAX_PACKETS)) begin
                            state <= ST_INSERT;
                        end else begin
                            state <= ST_DETOUR;
                        end
                    end
                end
                ST_INSERT, ST_DETOUR: begin
                    if (in_fire && in_flit.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && in_valid) begin
            detour_dest <= in_flit.data[compute_engine_pkg::DETOUR_BIT] ?
                           compute_engine_pkg::DETOUR_PORT_HI :
                           compute_engine_pkg::DETOUR_PORT_LO;
        end
    end

    // packets held in the buffer, up on insert and down on release
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_count <= '0;
        end else begin
            case ({sub_credit, release_pulse})
                2'b10:   pkt_count <= pkt_count + 1'b1;
                2'b01:   pkt_count <= pkt_count - 1'b1;
                default: pkt_count <= pkt_count;
            endcase
        end
    end

    always_comb begin
        in_ready     = 1'b0;
        buf_valid    = 1'b0;
        detour.valid = 1'b0;
        case (state)
            ST_INSERT: begin
                buf_valid = in_valid;
                in_ready  = buf_ready;
            end
            ST_DETOUR: begin
                detour.valid = in_valid;
                in_ready     = detour.ready;
            end
            default: ;
        endcase
    end

    assign buf_flit    = in_flit;
    assign detour.data = in_flit.data;
    assign detour.keep = in_flit.keep;
    assign detour.last = in_flit.last;
    assign detour.dest = detour_dest;

    assign sub_credit = (state == ST_INSERT) && in_fire && in_flit.last;

    count_bounded: assert property (
        @(posedge clk) disable iff (rst) pkt_count <= CNT_W'(MAX_PACKETS)
    );

    // compute stage only releases packets that were admitted
    release_has_packet: assert property (
        @(posedge clk) disable iff (rst) release_pulse |-> (pkt_count != '0 || sub_credit)
    );

endmodule

//--- logic/compute_stage.sv
`timescale 1ns/1ps

module compute_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      buf_valid,
    output logic                      buf_ready,
    input  compute_engine_pkg::flit_t buf_flit,
    flit_if.source                    computed,
    output logic                      release_pulse
);

    localparam int CHAIN_W = compute_engine_pkg::CHAIN_ITEMS * compute_engine_pkg::CHAIN_ITEM_W;
    localparam int DELAY_W = compute_engine_pkg::DELAY_W;
    localparam int DEST_W = compute_engine_pkg::DEST_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_HEAD,
        ST_DATA
    } state_t;

    state_t                                        state;
    logic [DELAY_W-1:0]                            delay_cnt;
    logic [DELAY_W-1:0]                            head_delay;
    logic [CHAIN_W-1:0]                            next_chain;
    logic [compute_engine_pkg::CHAIN_ITEM_W-1:0]   next_hop;
    logic [DEST_W-1:0]                             head_dest;
    logic [DEST_W-1:0]                             hop_dest;
    logic                                          out_fire;

    assign head_delay = buf_flit.data[compute_engine_pkg::DELAY_OF +: DELAY_W];

    // drop the hop just served, the lowest item is the next destination
    assign next_chain = buf_flit.data[compute_engine_pkg::CHAIN_OF +: CHAIN_W]
                        >> compute_engine_pkg::CHAIN_ITEM_W;
    assign next_hop   = next_chain[compute_engine_pkg::CHAIN_ITEM_W-1:0];
    assign head_dest  = (next_hop == '0) ? compute_engine_pkg::DMA_PORT : next_hop;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            delay_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (buf_valid) begin
                        delay_cnt <= head_delay;
                        state     <= (head_delay == '0) ? ST_HEAD : ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    delay_cnt <= delay_cnt - 1'b1;
                    if (delay_cnt == DELAY_W'(1)) begin
                        state <= ST_HEAD;
                    end
                end
                ST_HEAD: begin
                    if (out_fire) begin
                        state <= buf_flit.last ? ST_IDLE : ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (out_fire && buf_flit.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // data flits follow the head to the same port
    always_ff @(posedge clk) begin
        if (state == ST_HEAD && out_fire) begin
            hop_dest <= head_dest;
        end
    end

    always_comb begin
        computed.valid = 1'b0;
        computed.data  = buf_flit.data;
        computed.dest  = hop_dest;
        if (state == ST_HEAD) begin
            computed.valid = buf_valid;
            computed.data[compute_engine_pkg::CHAIN_OF +: CHAIN_W] = next_chain;
            computed.dest  = head_dest;
        end else if (state == ST_DATA) begin
            computed.valid = buf_valid;
        end
    end

    assign computed.keep = buf_flit.keep;
    assign computed.last = buf_flit.last;

    assign buf_ready     = (state == ST_HEAD || state == ST_DATA) && computed.ready;
    assign out_fire      = computed.valid && computed.ready;
    assign release_pulse = out_fire && buf_flit.last;

    computed_stable: assert property (
        @(posedge clk) disable iff (rst)
        computed.valid && !computed.ready |=>
            computed.valid && $stable(computed.data) && $stable(computed.keep) &&
            $stable(computed.last) && $stable(computed.dest)
    );

endmodule

//--- logic/egress_arbiter.sv
`timescale 1ns/1ps

module egress_arbiter (
    input  logic                             clk,
    input  logic                             rst,
    flit_if.sink                             detour,
    flit_if.sink                             computed,
    output logic                             out_valid,
    input  logic                             out_ready,
    output compute_engine_pkg::routed_flit_t out_flit
);

    // sel and grant: 0 is the detour bus, 1 is the computed bus
    logic locked;
    logic grant;
    logic sel;
    logic out_fire;

    // grant holds the last winner while unlocked, the other side goes first
    always_comb begin
        if (locked) begin
            sel = grant;
        end else if (detour.valid && computed.valid) begin
            sel = ~grant;
        end else begin
            sel = computed.valid;
        end
    end

    always_comb begin
        if (sel) begin
            out_valid          = computed.valid;
            out_flit.flit.data = computed.data;
            out_flit.flit.keep = computed.keep;
            out_flit.flit.last = computed.last;
            out_flit.dest      = computed.dest;
        end else begin
            out_valid          = detour.valid;
            out_flit.flit.data = detour.data;
            out_flit.flit.keep = detour.keep;
            out_flit.flit.last = detour.last;
            out_flit.dest      = detour.dest;
        end
    end

    assign detour.ready   = out_ready && !sel;
    assign computed.ready = out_ready && sel;
    assign out_fire       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            grant  <= 1'b0;
        end else if (out_fire) begin
            grant  <= sel;
            locked <= !out_flit.flit.last;
        end
    end

    grant_held: assert property (
        @(posedge clk) disable iff (rst)
        out_fire && !out_flit.flit.last |=> sel == $past(sel)
    );

endmodule

//--- logic/compute_engine.sv
`timescale 1ns/1ps

module compute_engine #(
    parameter int MAX_PACKETS = 2,
    parameter int BUFFER_DEPTH = 32,
    parameter int OUT_DEPTH = 16
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [compute_engine_pkg::DATA_W-1:0] in_data,
    input  logic [compute_engine_pkg::KEEP_W-1:0] in_keep,
    input  logic                                  in_last,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [compute_engine_pkg::DATA_W-1:0] out_data,
    output logic [compute_engine_pkg::KEEP_W-1:0] out_keep,
    output logic                                  out_last,
    output logic [compute_engine_pkg::DEST_W-1:0] out_dest,
    output compute_engine_pkg::credit_t           credit_control
);

    compute_engine_pkg::flit_t        in_flit;
    logic                             buf_in_valid;
    logic                             buf_in_ready;
    compute_engine_pkg::flit_t        buf_in_flit;
    logic                             buf_out_valid;
    logic                             buf_out_ready;
    compute_engine_pkg::flit_t        buf_out_flit;
    logic                             release_pulse;
    logic                             sub_credit;
    logic                             arb_valid;
    logic                             arb_ready;
    compute_engine_pkg::routed_flit_t arb_flit;
    compute_engine_pkg::routed_flit_t out_entry;

    flit_if detour_bus ();
    flit_if computed_bus ();

    assign in_flit.data = in_data;
    assign in_flit.keep = in_keep;
    assign in_flit.last = in_last;

    packet_admission #(
        .MAX_PACKETS(MAX_PACKETS)
    ) packet_admission_inst (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_flit(in_flit),
        .buf_valid(buf_in_valid),
        .buf_ready(buf_in_ready),
        .buf_flit(buf_in_flit),
        .detour(detour_bus.source),
        .release_pulse(release_pulse),
        .sub_credit(sub_credit)
    );

    flit_fifo #(
        .DEPTH(BUFFER_DEPTH),
        .entry_t(compute_engine_pkg::flit_t)
    ) packet_buffer (
        .clk(clk),
        .rst(rst),
        .in_valid(buf_in_valid),
        .in_ready(buf_in_ready),
        .in_entry(buf_in_flit),
        .out_valid(buf_out_valid),
        .out_ready(buf_out_ready),
        .out_entry(buf_out_flit)
    );

    compute_stage compute_stage_inst (
        .clk(clk),
        .rst(rst),
        .buf_valid(buf_out_valid),
        .buf_ready(buf_out_ready),
        .buf_flit(buf_out_flit),
        .computed(computed_bus.source),
        .release_pulse(release_pulse)
    );

    egress_arbiter egress_arbiter_inst (
        .clk(clk),
        .rst(rst),
        .detour(detour_bus.sink),
        .computed(computed_bus.sink),
        .out_valid(arb_valid),
        .out_ready(arb_ready),
        .out_flit(arb_flit)
    );

    flit_fifo #(
        .DEPTH(OUT_DEPTH),
        .entry_t(compute_engine_pkg::routed_flit_t)
    ) output_queue (
        .clk(clk),
        .rst(rst),
        .in_valid(arb_valid),
        .in_ready(arb_ready),
        .in_entry(arb_flit),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_entry(out_entry)
    );

    assign out_data = out_entry.flit.data;
    assign out_keep = out_entry.flit.keep;
    assign out_last = out_entry.flit.last;
    assign out_dest = out_entry.dest;

    // sub on each admitted packet, add when a computed packet leaves the buffer
    assign credit_control.sub = sub_credit;
    assign credit_control.add = release_pulse;

endmodule

//--- test/compute_engine_tb.sv
`timescale 1ns/1ps

module compute_engine_tb;

    localparam int DATA_W = compute_engine_pkg::DATA_W;
    localparam int KEEP_W = compute_engine_pkg::KEEP_W;
    localparam int DEST_W = compute_engine_pkg::DEST_W;
    localparam int ITEM_W = compute_engine_pkg::CHAIN_ITEM_W;
    localparam int ITEMS = compute_engine_pkg::CHAIN_ITEMS;
    localparam int CHAIN_OF = compute_engine_pkg::CHAIN_OF;
    localparam int CHAIN_W = ITEMS * ITEM_W;
    localparam int MAX_IDS = 64;
    localparam int MAX_LEN = 8;
    localparam int WAIT_LIMIT = 10000;

    logic                        clk;
    logic                        rst;
    logic                        in_valid;
    logic                        in_ready;
    logic [DATA_W-1:0]           in_data;
    logic [KEEP_W-1:0]           in_keep;
    logic                        in_last;
    logic                        out_valid;
    logic                        out_ready;
    logic [DATA_W-1:0]           out_data;
    logic [KEEP_W-1:0]           out_keep;
    logic                        out_last;
    logic [DEST_W-1:0]           out_dest;
    compute_engine_pkg::credit_t credit_control;

    integer                           seed = 32'h3307_b915;
    logic [DATA_W-1:0]                pkt_data [MAX_IDS][MAX_LEN];
    logic [KEEP_W-1:0]                pkt_keep [MAX_IDS][MAX_LEN];
    int                               pkt_len [MAX_IDS];
    bit                               pkt_detour [MAX_IDS];
    bit                               pkt_seen [MAX_IDS];
    int                               n_built = 0;
    int                               insert_count = 0;
    int                               rx_count = 0;
    int                               sub_count = 0;
    int                               add_count = 0;
    int                               rx_order [$];
    compute_engine_pkg::routed_flit_t rx_flits [$];
    bit                               toggle_ready = 1'b0;

    compute_engine #(
        .MAX_PACKETS(2),
        .BUFFER_DEPTH(32),
        .OUT_DEPTH(16)
    ) compute_engine_inst (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .in_keep(in_keep),
        .in_last(in_last),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data),
        .out_keep(out_keep),
        .out_last(out_last),
        .out_dest(out_dest),
        .credit_control(credit_control)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flit(input compute_engine_pkg::routed_flit_t got,
                              input compute_engine_pkg::routed_flit_t exp);
        if (got.flit.data !== exp.flit.data) begin
            report_failure($sformatf("Mismatch at %0t: out_data got 0x%h expected 0x%h",
                                     $time, got.flit.data, exp.flit.data));
        end
        if (got.flit.keep !== exp.flit.keep) begin
            report_failure($sformatf("Mismatch at %0t: out_keep got 0x%h expected 0x%h",
                                     $time, got.flit.keep, exp.flit.keep));
        end
        if (got.flit.last !== exp.flit.last) begin
            report_failure($sformatf("Mismatch at %0t: out_last got %b expected %b",
                                     $time, got.flit.last, exp.flit.last));
        end
        if (got.dest !== exp.dest) begin
            report_failure($sformatf("Mismatch at %0t: out_dest got %0d expected %0d",
                                     $time, got.dest, exp.dest));
        end
    endtask

    task automatic check_credit(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    // expected output flit k of packet id, from the descriptor rules
    function automatic compute_engine_pkg::routed_flit_t expected_flit(input int id, input int k);
        compute_engine_pkg::routed_flit_t exp;
        logic [DATA_W-1:0]                head;
        logic [ITEM_W-1:0]                hop;
        int                               i;
        head = pkt_data[id][0];
        exp.flit.data = pkt_data[id][k];
        exp.flit.keep = pkt_keep[id][k];
        exp.flit.last = (k == pkt_len[id] - 1);
        if (pkt_detour[id]) begin
            exp.dest = head[compute_engine_pkg::DETOUR_BIT] ?
                       compute_engine_pkg::DETOUR_PORT_HI : compute_engine_pkg::DETOUR_PORT_LO;
        end else begin
            // hop 1 of the incoming chain becomes the destination
            hop = head[CHAIN_OF + ITEM_W +: ITEM_W];
            exp.dest = (hop == '0) ? compute_engine_pkg::DMA_PORT : hop;
            if (k == 0) begin
                for (i = 0; i < ITEMS; i++) begin
                    exp.flit.data[CHAIN_OF + i * ITEM_W +: ITEM_W] = (i + 1 < ITEMS) ?
                        head[CHAIN_OF + (i + 1) * ITEM_W +: ITEM_W] : '0;
                end
            end
        end
        return exp;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + ($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic make_packet(input int delay, input logic [CHAIN_W-1:0] chain, input logic hi,
                               input int len, input bit detoured);
        logic [DATA_W-1:0] head;
        int                k;
        // sequence id rides in the upper half of the head
        head = {32'(n_built), $random(seed)};
        head[compute_engine_pkg::DELAY_OF +: compute_engine_pkg::DELAY_W] = delay[15:0];
        head[CHAIN_OF +: CHAIN_W] = chain;
        head[compute_engine_pkg::DETOUR_BIT] = hi;
        pkt_data[n_built][0] = head;
        pkt_len[n_built] = len;
        pkt_detour[n_built] = detoured;
        pkt_seen[n_built] = 1'b0;
        for (k = 0; k < len; k++) begin
            if (k > 0) begin
                pkt_data[n_built][k] = {$random(seed), $random(seed)};
            end
            pkt_keep[n_built][k] = (k == len - 1) ? KEEP_W'($random(seed)) : '1;
        end
        if (!detoured) begin
            insert_count++;
        end
        n_built++;
    endtask

    task automatic send_packet(input int id);
        int k;
        int cycles;
        @(posedge clk);
        #1;
        for (k = 0; k < pkt_len[id]; k++) begin
            in_valid = 1'b1;
            in_data  = pkt_data[id][k];
            in_keep  = pkt_keep[id][k];
            in_last  = (k == pkt_len[id] - 1);
            cycles   = 0;
            @(negedge clk);
            while (!in_ready) begin
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    report_failure($sformatf("packet %0d flit %0d was never accepted", id, k));
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_for_packets(input int n);
        int cycles;
        cycles = 0;
        while (rx_count < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_failure($sformatf("packet %0d never left the DUT", n - 1));
            end
        end
    endtask

    // outputs and credit bits are settled at the falling edge
    initial begin : output_monitor
        compute_engine_pkg::routed_flit_t got;
        int                               id;
        int                               k;
        forever begin
            @(negedge clk);
            if (credit_control.sub) begin
                sub_count++;
            end
            if (credit_control.add) begin
                add_count++;
            end
            if (out_valid && out_ready) begin
                got.flit.data = out_data;
                got.flit.keep = out_keep;
                got.flit.last = out_last;
                got.dest      = out_dest;
                rx_flits.push_back(got);
                if (out_last) begin
                    id = int'(rx_flits[0].flit.data[DATA_W-1:32]);
                    if (id < 0 || id >= n_built || pkt_seen[id]) begin
                        report_failure($sformatf("unknown or repeated packet id %0d at output", id));
                    end
                    if (rx_flits.size() != pkt_len[id]) begin
                        report_failure($sformatf("packet %0d left with %0d flits instead of %0d",
                                                 id, rx_flits.size(), pkt_len[id]));
                    end
                    for (k = 0; k < pkt_len[id]; k++) begin
                        check_flit(rx_flits[k], expected_flit(id, k));
                    end
                    pkt_seen[id] = 1'b1;
                    rx_order.push_back(id);
                    rx_count++;
                    rx_flits.delete();
                end
            end
        end
    end

    initial begin : ready_toggle
        forever begin
            @(posedge clk);
            #1;
            if (toggle_ready) begin
                out_ready = $random(seed) & 1;
            end
        end
    end

    initial begin : stimulus
        int i;
        int first;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        in_keep   = '0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst       = 1'b0;
        out_ready = 1'b1;
        repeat (3) @(posedge clk);
        check_credit("credit_control pulses after reset", sub_count + add_count, 0);
        check_credit("out_valid after reset", int'(out_valid), 0);

        // one packet at a time, zero delay and an exhausted chain included
        make_packet(0, {3'd0, 3'd0, 3'd5, 3'd2}, 1'b0, 1, 1'b0);
        make_packet(3, {3'd4, 3'd6, 3'd0, 3'd7}, 1'b1, 4, 1'b0);
        make_packet(0, '0, 1'b0, 8, 1'b0);
        for (i = 0; i < 3; i++) begin
            make_packet(rand_range(0, 15), CHAIN_W'($random(seed)), 1'b0, rand_range(1, 8), 1'b0);
        end
        for (i = 0; i < n_built; i++) begin
            send_packet(i);
            wait_for_packets(i + 1);
        end

        // two long computes fill the count, the third packet must detour
        first = n_built;
        make_packet(2000, CHAIN_W'($random(seed)), 1'b0, rand_range(1, 8), 1'b0);
        make_packet(2000, CHAIN_W'($random(seed)), 1'b1, rand_range(1, 8), 1'b0);
        make_packet(rand_range(0, 15), CHAIN_W'($random(seed)), 1'b1, rand_range(1, 8), 1'b1);
        @(posedge clk);
        #1;
        out_ready = 1'b0;
        send_packet(first);
        send_packet(first + 1);
        send_packet(first + 2);
        out_ready = 1'b1;
        wait_for_packets(first + 3);
        if (rx_order[first] != first + 2 || rx_order[first + 1] != first ||
            rx_order[first + 2] != first + 1) begin
            report_failure("detoured packet did not leave ahead of the two held packets");
        end

        // stream under random back-pressure, at most two packets in flight
        first = n_built;
        for (i = 0; i < 40; i++) begin
            make_packet(rand_range(0, 15), CHAIN_W'($random(seed)), rand_range(0, 1),
                        rand_range(1, 8), 1'b0);
        end
        @(negedge clk);
        toggle_ready = 1'b1;
        for (i = first; i < first + 40; i++) begin
            wait_for_packets(i - 1);
            send_packet(i);
        end
        wait_for_packets(first + 40);
        @(negedge clk);
        toggle_ready = 1'b0;
        @(posedge clk);
        #1;
        out_ready = 1'b1;

        repeat (20) @(posedge clk);
        // nothing may trail the last packet
        check_credit("output flits after the last packet", rx_flits.size(), 0);
        check_credit("credit_control.sub pulses", sub_count, insert_count);
        check_credit("credit_control.add pulses", add_count, sub_count);
        $display("Regression passed");
        $finish;
    end

endmodule

//--- vlog.f
logic/compute_engine_pkg.sv
logic/flit_if.sv
logic/flit_fifo.sv
logic/packet_admission.sv
logic/compute_stage.sv
logic/egress_arbiter.sv
logic/compute_engine.sv
test/compute_engine_tb.sv

//--- Bender.yml
package:
  name: compute_engine

sources:
  - logic/compute_engine_pkg.sv
  - logic/flit_if.sv
  - logic/flit_fifo.sv
  - logic/packet_admission.sv
  - logic/compute_stage.sv
  - logic/egress_arbiter.sv
  - logic/compute_engine.sv
  - target: test
    files:
      - test/compute_engine_tb.sv
